/* hw/dualDecode_macros.svh */
`ifndef DUAL_DECODE_MACROS_SVH
`define DUAL_DECODE_MACROS_SVH

`define DD_INSTR_W  32 // instruction word
`define DD_WB_ADR_W 2  // word address, four registers
`define DD_WB_DAT_W 32 // wishbone data bus
`define DD_CNT_W    16 // event counters, saturating

`endif

/* hw/isaPkg.sv */
package isaPkg;

  // mode register encoding, also the status bit
  typedef enum logic {
    isaRv  = 1'b0,
    isaArm = 1'b1
  } isaModeT;

  // alu operation, arm codes are the low four entries
  typedef enum logic [3:0] {
    aluAdd = 4'b0000,
    aluSub = 4'b0001,
    aluAnd = 4'b0010,
    aluOr  = 4'b0011,
    aluXor = 4'b0100,
    aluSlt = 4'b0101, // slt and sltu
    aluLui = 4'b0110, // pass immediate
    aluSll = 4'b1000,
    aluSrl = 4'b1001,
    aluSra = 4'b1010
  } aluCtrlT;

  typedef enum logic [1:0] {
    memByte = 2'b00,
    memHalf = 2'b01,
    memWord = 2'b10
  } memSizeT;

  // arm reuses the low three codes for imm8, imm12 and imm24
  typedef enum logic [2:0] {
    immI = 3'b000,
    immS = 3'b001,
    immB = 3'b010,
    immJ = 3'b011,
    immU = 3'b111
  } immSrcT;

  typedef enum logic [1:0] {
    resAlu = 2'b00,
    resMem = 2'b01,
    resPc4 = 2'b10 // also pc relative with pcRes
  } resultSrcT;

endpackage

/* hw/wbPkg.sv */
`include "dualDecode_macros.svh"

package wbPkg;

  // word addresses of the register block
  typedef enum logic [`DD_WB_ADR_W-1:0] {
    regCtrl   = 0,
    regStatus = 1,
    regDecCnt = 2,
    regIllCnt = 3
  } regAddrT;

  localparam int ctrlForceBit = 0; // force the selected isa
  localparam int ctrlModeBit  = 1; // isa used while forced

endpackage

/* hw/rvDecoder.sv */
`include "dualDecode_macros.svh"

module rvDecoder (
  input  logic [`DD_INSTR_W-1:0] instr,
  output logic                   rvValid,
  output logic                   regWrite,
  output logic                   memWrite,
  output isaPkg::memSizeT        memSize,
  output logic                   memSigned,
  output isaPkg::aluCtrlT        aluControl,
  output logic                   branch,
  output logic                   aluSrc,
  output isaPkg::immSrcT         immSrc,
  output isaPkg::resultSrcT      resultSrc,
  output logic                   jump,
  output logic                   pcRes
);
  import isaPkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  logic       rTypeSub;
  logic [1:0] aluOp; // 00 add, 01 sub, 10 by funct3, 11 lui

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];
  assign rTypeSub = funct7b5 & opcode[5]; // immediate form has no sub

  // main decoder
  always_comb begin
    rvValid   = 1'b1;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    memSize   = memByte;
    memSigned = 1'b0;
    branch    = 1'b0;
    aluSrc    = 1'b0;
    immSrc    = immI;
    resultSrc = resAlu;
    jump      = 1'b0;
    pcRes     = 1'b0;
    aluOp     = 2'b00;
    case (opcode)
      7'b0000011: begin // lb lh lw lbu lhu
        regWrite  = 1'b1;
        aluSrc    = 1'b1;
        resultSrc = resMem;
        memSize   = memSizeT'(funct3[1:0]);
        memSigned = ~funct3[2] & ~funct3[1];
        rvValid   = (funct3[1:0] != 2'b11) & ~(funct3[2] & funct3[1]);
      end
      7'b0100011: begin // sb sh sw
        memWrite = 1'b1;
        aluSrc   = 1'b1;
        immSrc   = immS;
        memSize  = memSizeT'(funct3[1:0]);
        rvValid  = ~funct3[2] & (funct3[1:0] != 2'b11);
      end
      7'b0110011: begin // r-type
        regWrite = 1'b1;
        aluOp    = 2'b10;
      end
      7'b0010011: begin // i-type alu
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        aluOp    = 2'b10;
      end
      7'b1100011: begin
        branch  = 1'b1;
        immSrc  = immB;
        aluOp   = 2'b01;
        rvValid = (funct3 == 3'b000); // beq only
      end
      7'b1101111: begin // jal
        regWrite  = 1'b1;
        immSrc    = immJ;
        resultSrc = resPc4;
        jump      = 1'b1;
      end
      7'b0110111: begin // lui
        regWrite = 1'b1;
        immSrc   = immU;
        aluSrc   = 1'b1;
        aluOp    = 2'b11;
      end
      7'b0010111: begin // auipc writes pc + imm
        regWrite  = 1'b1;
        immSrc    = immU;
        aluSrc    = 1'b1;
        resultSrc = resPc4;
        pcRes     = 1'b1;
      end
      default: rvValid = 1'b0;
    endcase
  end

  // alu decoder, every funct3 is covered
  always_comb begin
    case (aluOp)
      2'b00: aluControl = aluAdd;
      2'b01: aluControl = aluSub;
      2'b11: aluControl = aluLui;
      default: begin
        case (funct3)
          3'b000:         aluControl = rTypeSub ? aluSub : aluAdd;
          3'b001:         aluControl = aluSll;
          3'b010, 3'b011: aluControl = aluSlt;
          3'b100:         aluControl = aluXor;
          3'b101:         aluControl = funct7b5 ? aluSra : aluSrl;
          3'b110:         aluControl = aluOr;
          default:        aluControl = aluAnd;
        endcase
      end
    endcase
  end

endmodule

/* hw/armDecoder.sv */
`include "dualDecode_macros.svh"

module armDecoder (
  input  logic [`DD_INSTR_W-1:0] instr,
  output logic                   armValid,
  output logic                   regWrite,
  output logic                   memWrite,
  output isaPkg::memSizeT        memSize,
  output logic                   memSigned,
  output isaPkg::aluCtrlT        aluControl,
  output logic                   branch,
  output logic                   aluSrc,
  output isaPkg::immSrcT         immSrc,
  output isaPkg::resultSrcT      resultSrc,
  output logic                   pcSrc,
  output logic [1:0]             flagWrite,
  output logic [1:0]             regSrc
);
  import isaPkg::*;

  logic [1:0] op;
  logic [5:0] funct; // I/opcode/S or I/P/U/B/W/L
  logic [3:0] rd;
  logic       aluOp;
  logic       mainValid;
  logic       aluValid;

  assign op    = instr[27:26];
  assign funct = instr[25:20];
  assign rd    = instr[15:12];

  always_comb begin
    mainValid = 1'b1;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    memSize   = memByte;
    branch    = 1'b0;
    aluSrc    = 1'b0;
    immSrc    = immI; // imm8 rotated
    resultSrc = resAlu;
    regSrc    = 2'b00;
    aluOp     = 1'b0;
    case (op)
      2'b00: begin // data processing
        regWrite = 1'b1;
        aluSrc   = funct[5];
        aluOp    = 1'b1;
      end
      2'b01: begin
        aluSrc    = 1'b1;
        immSrc    = immS; // imm12 offset
        memSize   = memWord;
        mainValid = ~funct[2]; // no byte transfers
        if (funct[0]) begin // ldr
          regWrite  = 1'b1;
          resultSrc = resMem;
        end else begin // str reads rd as data
          memWrite = 1'b1;
          regSrc   = 2'b10;
        end
      end
      2'b10: begin // b
        branch = 1'b1;
        aluSrc = 1'b1;
        immSrc = immB; // imm24
        regSrc = 2'b01;
      end
      default: mainValid = 1'b0;
    endcase
  end

  always_comb begin
    aluValid   = 1'b1;
    aluControl = aluAdd; // address add for memory and branch
    flagWrite  = 2'b00;
    if (aluOp) begin
      case (funct[4:1])
        4'b0100: aluControl = aluAdd;
        4'b0010: aluControl = aluSub;
        4'b0000: aluControl = aluAnd;
        4'b1100: aluControl = aluOr;
        default: aluValid = 1'b0;
      endcase
      flagWrite[1] = funct[0]; // n and z on any s bit
      flagWrite[0] = funct[0] & ((funct[4:1] == 4'b0100) | (funct[4:1] == 4'b0010));
    end
  end

  assign memSigned = 1'b0; // word loads only
  assign armValid  = mainValid & aluValid;
  assign pcSrc     = regWrite & (rd == 4'hf);

endmodule

/* hw/isaSelect.sv */
module isaSelect (
  input  isaPkg::isaModeT   curMode,
  input  logic              forceEn,
  input  isaPkg::isaModeT   forceMode,
  input  logic              rvValid,
  input  logic              armValid,
  input  logic              rvRegWrite,
  input  logic              rvMemWrite,
  input  isaPkg::memSizeT   rvMemSize,
  input  logic              rvMemSigned,
  input  isaPkg::aluCtrlT   rvAluControl,
  input  logic              rvBranch,
  input  logic              rvAluSrc,
  input  isaPkg::immSrcT    rvImmSrc,
  input  isaPkg::resultSrcT rvResultSrc,
  input  logic              rvJump,
  input  logic              rvPcRes,
  input  logic              armRegWrite,
  input  logic              armMemWrite,
  input  isaPkg::memSizeT   armMemSize,
  input  logic              armMemSigned,
  input  isaPkg::aluCtrlT   armAluControl,
  input  logic              armBranch,
  input  logic              armAluSrc,
  input  isaPkg::immSrcT    armImmSrc,
  input  isaPkg::resultSrcT armResultSrc,
  input  logic              armPcSrc,
  input  logic [1:0]        armFlagWrite,
  input  logic [1:0]        armRegSrc,
  output isaPkg::isaModeT   nextMode,
  output logic              illegal,
  output logic              regWrite,
  output logic              memWrite,
  output isaPkg::memSizeT   memSize,
  output logic              memSigned,
  output isaPkg::aluCtrlT   aluControl,
  output logic              branch,
  output logic              aluSrc,
  output isaPkg::immSrcT    immSrc,
  output isaPkg::resultSrcT resultSrc,
  output logic              pcSrc,
  output logic [1:0]        flagWrite,
  output logic [1:0]        regSrc,
  output logic              jump,
  output logic              pcRes
);
  import isaPkg::*;

  // the selected isa is also the mode after retire
  always_comb begin
    if (forceEn) nextMode = forceMode;
    else if (rvValid ^ armValid) nextMode = armValid ? isaArm : isaRv;
    else nextMode = curMode; // ambiguous or unknown keeps mode
  end

  assign illegal = (nextMode == isaArm) ? ~armValid : ~rvValid;

  always_comb begin
    if (nextMode == isaArm) begin
      regWrite   = armRegWrite;
      memWrite   = armMemWrite;
      memSize    = armMemSize;
      memSigned  = armMemSigned;
      aluControl = armAluControl;
      branch     = armBranch;
      aluSrc     = armAluSrc;
      immSrc     = armImmSrc;
      resultSrc  = armResultSrc;
      pcSrc      = armPcSrc;
      flagWrite  = armFlagWrite;
      regSrc     = armRegSrc;
      jump       = 1'b0;
      pcRes      = 1'b0;
    end else begin
      regWrite   = rvRegWrite;
      memWrite   = rvMemWrite;
      memSize    = rvMemSize;
      memSigned  = rvMemSigned;
      aluControl = rvAluControl;
      branch     = rvBranch;
      aluSrc     = rvAluSrc;
      immSrc     = rvImmSrc;
      resultSrc  = rvResultSrc;
      pcSrc      = 1'b0;
      flagWrite  = 2'b00;
      regSrc     = 2'b00;
      jump       = rvJump;
      pcRes      = rvPcRes;
    end
    if (illegal) begin // no architectural side effects
      regWrite = 1'b0;
      memWrite = 1'b0;
      branch   = 1'b0;
      jump     = 1'b0;
      pcSrc    = 1'b0;
    end
  end

endmodule

/* hw/decodeStage.sv */
`include "dualDecode_macros.svh"

module decodeStage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`DD_INSTR_W-1:0] instr,
  input  logic                   instrValid,
  input  logic                   stall,
  input  logic                   flush,
  input  isaPkg::isaModeT        nextMode,
  output logic [`DD_INSTR_W-1:0] curInstr,
  output logic                   outValid,
  output isaPkg::isaModeT        curMode,
  output logic                   retire
);
  import isaPkg::*;

  // addi x0, x0, 0 is legal in both isas and keeps the rv mode
  localparam logic [`DD_INSTR_W-1:0] nopInstr = 32'h0000_0013;

  logic accept;

  assign accept = instrValid & ~stall & ~flush;
  assign retire = outValid & ~stall & ~flush; // flushed slot never retires

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
      curMode  <= isaRv;
      curInstr <= nopInstr;
    end else begin
      if (flush) begin
        outValid <= 1'b0;
      end else if (!stall) begin
        outValid <= instrValid;
      end
      if (accept) begin
        curInstr <= instr;
      end
      if (retire) begin
        curMode <= nextMode;
      end
    end
  end

endmodule

/* hw/decodeCsr.sv */
`include "dualDecode_macros.svh"

module decodeCsr (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  wbPkg::regAddrT          adr,
  input  logic [`DD_WB_DAT_W-1:0] datW,
  input  isaPkg::isaModeT         curMode,
  input  logic                    retire,
  input  logic                    illegal,
  output logic                    ack,
  output logic [`DD_WB_DAT_W-1:0] datR,
  output logic                    forceEn,
  output isaPkg::isaModeT         forceMode
);
  import isaPkg::*;
  import wbPkg::*;

  logic                    access;
  logic                    wrEn;
  logic [`DD_CNT_W-1:0]    decCnt;
  logic [`DD_CNT_W-1:0]    illCnt;
  logic [`DD_WB_DAT_W-1:0] rdMux;

  function automatic logic [`DD_CNT_W-1:0] satInc(input logic [`DD_CNT_W-1:0] cnt);
    return (cnt == '1) ? cnt : cnt + 1'b1; // stick at top value
  endfunction

  assign access = cyc & stb & ~ack; // one ack per request
  assign wrEn   = access & we;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack       <= 1'b0;
      forceEn   <= 1'b0;
      forceMode <= isaRv;
      decCnt    <= '0;
      illCnt    <= '0;
    end else begin
      ack <= access;
      if (wrEn && adr == regCtrl) begin
        forceEn   <= datW[ctrlForceBit];
        forceMode <= isaModeT'(datW[ctrlModeBit]);
      end
      if (wrEn && adr == regDecCnt) decCnt <= '0;
      else if (retire) decCnt <= satInc(decCnt);
      if (wrEn && adr == regIllCnt) illCnt <= '0;
      else if (retire && illegal) illCnt <= satInc(illCnt);
    end
  end

  always_comb begin
    rdMux = '0;
    case (adr)
      regCtrl: begin
        rdMux[ctrlForceBit] = forceEn;
        rdMux[ctrlModeBit]  = forceMode;
      end
      regStatus: rdMux[0] = curMode;
      regDecCnt: rdMux = `DD_WB_DAT_W'(decCnt);
      default:   rdMux = `DD_WB_DAT_W'(illCnt);
    endcase
  end

  // captured with the request, held while ack is high
  always_ff @(posedge clk) begin
    if (access) datR <= rdMux;
  end

endmodule

/* hw/dualDecodeTop.sv */
`include "dualDecode_macros.svh"

module dualDecodeTop (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`DD_INSTR_W-1:0]  instr,
  input  logic                    instrValid,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  wbPkg::regAddrT          adr,
  input  logic [`DD_WB_DAT_W-1:0] datW,
  output logic                    ack,
  output logic [`DD_WB_DAT_W-1:0] datR,
  output logic                    outValid,
  output isaPkg::isaModeT         armMode,
  output logic                    illegal,
  output logic                    regWrite,
  output logic                    memWrite,
  output isaPkg::memSizeT         memSize,
  output logic                    memSigned,
  output isaPkg::aluCtrlT         aluControl,
  output logic                    branch,
  output logic                    aluSrc,
  output isaPkg::immSrcT          immSrc,
  output isaPkg::resultSrcT       resultSrc,
  output logic                    pcSrc,
  output logic [1:0]              flagWrite,
  output logic [1:0]              regSrc,
  output logic                    jump,
  output logic                    pcRes
);
  import isaPkg::*;

  logic [`DD_INSTR_W-1:0] curInstr;
  isaModeT                curMode, forceMode;
  logic                   retire, forceEn;
  logic                   rvValid, armValid;
  logic                   rvRegWrite, rvMemWrite, rvMemSigned, rvBranch, rvAluSrc;
  logic                   rvJump, rvPcRes;
  memSizeT                rvMemSize, armMemSize;
  aluCtrlT                rvAluControl, armAluControl;
  immSrcT                 rvImmSrc, armImmSrc;
  resultSrcT              rvResultSrc, armResultSrc;
  logic                   armRegWrite, armMemWrite, armMemSigned, armBranch, armAluSrc;
  logic                   armPcSrc;
  logic [1:0]             armFlagWrite, armRegSrc;

  // selected isa feeds the mode register and the armMode output
  decodeStage decodeStage_i (.*, .nextMode(armMode));

  rvDecoder rvDecoder_i (
    .instr(curInstr), .rvValid(rvValid),
    .regWrite(rvRegWrite), .memWrite(rvMemWrite),
    .memSize(rvMemSize), .memSigned(rvMemSigned),
    .aluControl(rvAluControl), .branch(rvBranch),
    .aluSrc(rvAluSrc), .immSrc(rvImmSrc),
    .resultSrc(rvResultSrc), .jump(rvJump), .pcRes(rvPcRes)
  );

  armDecoder armDecoder_i (
    .instr(curInstr), .armValid(armValid),
    .regWrite(armRegWrite), .memWrite(armMemWrite),
    .memSize(armMemSize), .memSigned(armMemSigned),
    .aluControl(armAluControl), .branch(armBranch),
    .aluSrc(armAluSrc), .immSrc(armImmSrc),
    .resultSrc(armResultSrc), .pcSrc(armPcSrc),
    .flagWrite(armFlagWrite), .regSrc(armRegSrc)
  );

  isaSelect isaSelect_i (.*, .nextMode(armMode));

  decodeCsr decodeCsr_i (.*);

endmodule

/* tb/decodeChecks.svh */
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

// each encoding decodes in one isa only unless noted
localparam logic [`DD_INSTR_W-1:0] instrAdd     = 32'h003100B3; // add x1, x2, x3
localparam logic [`DD_INSTR_W-1:0] instrSub     = 32'h403100B3; // sub x1, x2, x3
localparam logic [`DD_INSTR_W-1:0] instrSra     = 32'h403150B3; // sra x1, x2, x3
localparam logic [`DD_INSTR_W-1:0] instrLw      = 32'h00C12083; // lw x1, 12(x2)
localparam logic [`DD_INSTR_W-1:0] instrLh      = 32'h00211083; // lh x1, 2(x2)
localparam logic [`DD_INSTR_W-1:0] instrSb      = 32'h00310023; // sb x3, 0(x2)
localparam logic [`DD_INSTR_W-1:0] instrBeq     = 32'h00208463; // beq x1, x2, 8
localparam logic [`DD_INSTR_W-1:0] instrJal     = 32'h010000EF; // jal x1, 16
localparam logic [`DD_INSTR_W-1:0] instrLui     = 32'h123450B7; // lui x1, 0x12345
localparam logic [`DD_INSTR_W-1:0] instrAuipc   = 32'h00300097; // auipc x1, 0x300
localparam logic [`DD_INSTR_W-1:0] instrLuiHigh = 32'h0C0000B7; // arm op field 11
localparam logic [`DD_INSTR_W-1:0] instrAdds    = 32'hE0921004; // adds r1, r2, r4
localparam logic [`DD_INSTR_W-1:0] instrLdr     = 32'hE5921004; // ldr r1, [r2, #4]
localparam logic [`DD_INSTR_W-1:0] instrB       = 32'hEA000004; // b +4 words
localparam logic [`DD_INSTR_W-1:0] instrOrrPc   = 32'hE180F003; // orr pc, r0, r3
localparam logic [`DD_INSTR_W-1:0] instrNop     = 32'h00000013; // addi x0 / and r0, legal in both
localparam logic [`DD_INSTR_W-1:0] instrAllOnes = 32'hFFFFFFFF; // legal in neither

task automatic stopRun();
  $display("TESTS FAILED");
  $fatal(1, "run stopped at first error");
endtask

task automatic valueFail(input string what, input logic [31:0] got, input logic [31:0] exp);
  $display("FAIL at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
  stopRun();
endtask

task automatic timeoutFail(input string what);
  $display("Timeout at time %0t: %s", $time, what);
  stopRun();
endtask

task automatic checkMode(input isaModeT got, input isaModeT exp, input string what);
  if (got !== exp) valueFail(what, 32'(got), 32'(exp));
endtask

task automatic checkAlu(input aluCtrlT got, input aluCtrlT exp, input string what);
  if (got !== exp) valueFail(what, 32'(got), 32'(exp));
endtask

task automatic checkImm(input immSrcT got, input immSrcT exp, input string what);
  if (got !== exp) valueFail(what, 32'(got), 32'(exp));
endtask

task automatic checkSize(input memSizeT got, input memSizeT exp, input string what);
  if (got !== exp) valueFail(what, 32'(got), 32'(exp));
endtask

task automatic checkRes(input resultSrcT got, input resultSrcT exp, input string what);
  if (got !== exp) valueFail(what, 32'(got), 32'(exp));
endtask

// illegal, regWrite, memWrite, memSigned, branch, aluSrc, pcSrc, jump, pcRes,
// flagWrite, regSrc
task automatic checkFlags(input logic [12:0] got, input logic [12:0] exp, input string what);
  if (got !== exp) valueFail(what, 32'(got), 32'(exp));
endtask

task automatic checkWord(input logic [31:0] got, input logic [31:0] exp, input string what);
  if (got !== exp) valueFail(what, got, exp);
endtask

task automatic waitAck();
  int n;
  n = 0;
  while (ack !== 1'b1) begin
    if (n == 10) timeoutFail("register block gave no ack within 10 cycles");
    @(negedge clk);
    n++;
  end
endtask

task automatic wbWrite(input regAddrT a, input logic [`DD_WB_DAT_W-1:0] d);
  @(negedge clk);
  cyc  = 1'b1;
  stb  = 1'b1;
  we   = 1'b1;
  adr  = a;
  datW = d;
  @(negedge clk);
  waitAck();
  cyc = 1'b0; // end of cycle once ack is seen
  stb = 1'b0;
  we  = 1'b0;
endtask

task automatic wbReadCheck(input regAddrT a, input logic [`DD_WB_DAT_W-1:0] exp,
                           input string what);
  @(negedge clk);
  cyc = 1'b1;
  stb = 1'b1;
  we  = 1'b0;
  adr = a;
  @(negedge clk);
  waitAck();
  checkWord(datR, exp, what); // valid while ack is high
  cyc = 1'b0;
  stb = 1'b0;
endtask

`endif

/* tb/dualDecodeTb.sv */
`include "dualDecode_macros.svh"

module dualDecodeTb;
  import isaPkg::*;
  import wbPkg::*;

  logic                    clk;
  logic                    reset;
  logic [`DD_INSTR_W-1:0]  instr;
  logic                    instrValid, stall, flush;
  logic                    cyc, stb, we, ack;
  regAddrT                 adr;
  logic [`DD_WB_DAT_W-1:0] datW, datR;
  logic                    outValid, illegal, regWrite, memWrite, memSigned;
  logic                    branch, aluSrc, pcSrc, jump, pcRes;
  isaModeT                 armMode;
  memSizeT                 memSize;
  aluCtrlT                 aluControl;
  immSrcT                  immSrc;
  resultSrcT               resultSrc;
  logic [1:0]              flagWrite, regSrc;
  int                      expDec, expIll; // retirements driven so far

  `include "decodeChecks.svh"

  dualDecodeTop dualDecodeTop_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic idleGap();
    repeat ($urandom_range(3)) @(negedge clk);
  endtask

  task automatic waitOutValid();
    int n;
    n = 0;
    while (outValid !== 1'b1) begin
      if (n == 20) timeoutFail("outValid did not rise within 20 cycles");
      @(negedge clk);
      n++;
    end
  endtask

  // one cycle of instrValid, then wait for the decoded result
  task automatic sendInstr(input logic [`DD_INSTR_W-1:0] code);
    @(negedge clk);
    instr      = code;
    instrValid = 1'b1;
    @(negedge clk);
    instrValid = 1'b0;
    waitOutValid();
  endtask

  task automatic decodeStep(input logic [`DD_INSTR_W-1:0] code, input isaModeT expMode,
                            input logic [12:0] expFlags, input aluCtrlT expAlu,
                            input immSrcT expImm, input memSizeT expSize,
                            input resultSrcT expRes, input string name);
    idleGap();
    sendInstr(code);
    checkMode(armMode, expMode, {name, " mode"});
    checkFlags({illegal, regWrite, memWrite, memSigned, branch, aluSrc, pcSrc, jump, pcRes,
                flagWrite, regSrc}, expFlags, {name, " flags"});
    checkAlu(aluControl, expAlu, {name, " aluControl"});
    checkImm(immSrc, expImm, {name, " immSrc"});
    checkSize(memSize, expSize, {name, " memSize"});
    checkRes(resultSrc, expRes, {name, " resultSrc"});
    expDec++;
    if (expFlags[12]) expIll++;
  endtask

  task automatic testAfterReset();
    @(negedge clk);
    checkWord(32'(outValid), 0, "outValid after reset");
    checkWord(32'(ack), 0, "ack after reset");
    checkMode(armMode, isaRv, "mode after reset");
    wbReadCheck(regStatus, 0, "status after reset");
    wbReadCheck(regDecCnt, 0, "decoded count after reset");
    wbReadCheck(regIllCnt, 0, "illegal count after reset");
  endtask

  task automatic testRvDecode();
    decodeStep(instrAdd, isaRv, 13'b0_1_0_0_0_0_0_0_0_00_00, aluAdd, immI, memByte, resAlu,
               "add");
    decodeStep(instrSub, isaRv, 13'b0_1_0_0_0_0_0_0_0_00_00, aluSub, immI, memByte, resAlu,
               "sub");
    decodeStep(instrSra, isaRv, 13'b0_1_0_0_0_0_0_0_0_00_00, aluSra, immI, memByte, resAlu,
               "sra");
    decodeStep(instrLw, isaRv, 13'b0_1_0_0_0_1_0_0_0_00_00, aluAdd, immI, memWord, resMem,
               "lw");
    decodeStep(instrLh, isaRv, 13'b0_1_0_1_0_1_0_0_0_00_00, aluAdd, immI, memHalf, resMem,
               "lh"); // signed half load
    decodeStep(instrSb, isaRv, 13'b0_0_1_0_0_1_0_0_0_00_00, aluAdd, immS, memByte, resAlu,
               "sb");
    decodeStep(instrBeq, isaRv, 13'b0_0_0_0_1_0_0_0_0_00_00, aluSub, immB, memByte, resAlu,
               "beq");
    decodeStep(instrJal, isaRv, 13'b0_1_0_0_0_0_0_1_0_00_00, aluAdd, immJ, memByte, resPc4,
               "jal");
    decodeStep(instrLui, isaRv, 13'b0_1_0_0_0_1_0_0_0_00_00, aluLui, immU, memByte, resAlu,
               "lui");
    decodeStep(instrAuipc, isaRv, 13'b0_1_0_0_0_1_0_0_1_00_00, aluAdd, immU, memByte, resPc4,
               "auipc"); // pc relative result
  endtask

  task automatic testIsaSwitch();
    decodeStep(instrAdds, isaArm, 13'b0_1_0_0_0_0_0_0_0_11_00, aluAdd, immI, memByte, resAlu,
               "adds");
    decodeStep(instrLdr, isaArm, 13'b0_1_0_0_0_1_0_0_0_00_00, aluAdd, immS, memWord, resMem,
               "ldr");
    decodeStep(instrB, isaArm, 13'b0_0_0_0_1_1_0_0_0_00_01, aluAdd, immB, memByte, resAlu,
               "b");
    decodeStep(instrOrrPc, isaArm, 13'b0_1_0_0_0_0_1_0_0_00_00, aluOr, immI, memByte, resAlu,
               "orr pc");
    // legal in both, arm mode is kept
    decodeStep(instrNop, isaArm, 13'b0_1_0_0_0_0_0_0_0_00_00, aluAnd, immI, memByte, resAlu,
               "nop in arm");
  endtask

  task automatic testIllegal();
    decodeStep(instrAllOnes, isaArm, 13'b1_0_0_0_0_0_0_0_0_00_00, aluAdd, immI, memByte,
               resAlu, "illegal in arm");
    wbReadCheck(regStatus, 1, "status after illegal in arm");
    decodeStep(instrAdd, isaRv, 13'b0_1_0_0_0_0_0_0_0_00_00, aluAdd, immI, memByte, resAlu,
               "add back to rv");
    decodeStep(instrAllOnes, isaRv, 13'b1_0_0_0_0_0_0_0_0_00_00, aluAdd, immI, memByte,
               resAlu, "illegal in rv");
    wbReadCheck(regStatus, 0, "status after illegal in rv");
  endtask

  task automatic testStallFlush();
    idleGap();
    sendInstr(instrSub);
    stall      = 1'b1;
    instr      = instrAllOnes; // offered but must not enter
    instrValid = 1'b1;
    repeat (3) begin
      @(negedge clk);
      checkWord(32'(outValid), 1, "outValid under stall");
      checkAlu(aluControl, aluSub, "aluControl under stall");
      checkWord(32'(illegal), 0, "illegal under stall");
    end
    stall      = 1'b0;
    instrValid = 1'b0;
    expDec++;
    sendInstr(instrAdds);
    checkMode(armMode, isaArm, "pending adds mode");
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    checkWord(32'(outValid), 0, "outValid after flush");
    wbReadCheck(regStatus, 0, "status after flush");
    decodeStep(instrNop, isaRv, 13'b0_1_0_0_0_1_0_0_0_00_00, aluAdd, immI, memByte, resAlu,
               "nop after flush");
  endtask

  task automatic testRegBlock();
    wbReadCheck(regDecCnt, expDec, "decoded count");
    wbReadCheck(regIllCnt, expIll, "illegal count");
    wbWrite(regCtrl, 32'h3); // force on, arm
    wbReadCheck(regCtrl, 32'h3, "control readback");
    decodeStep(instrLuiHigh, isaArm, 13'b1_0_0_0_0_0_0_0_0_00_00, aluAdd, immI, memByte,
               resAlu, "forced lui");
    wbReadCheck(regStatus, 1, "status while forced");
    wbWrite(regCtrl, 32'h0);
    decodeStep(instrLuiHigh, isaRv, 13'b0_1_0_0_0_1_0_0_0_00_00, aluLui, immU, memByte,
               resAlu, "lui after release");
    wbReadCheck(regStatus, 0, "status after release");
    wbReadCheck(regDecCnt, expDec, "decoded count before clear");
    wbReadCheck(regIllCnt, expIll, "illegal count before clear");
    wbWrite(regDecCnt, 32'hFFFF);
    wbWrite(regIllCnt, 32'h0);
    wbReadCheck(regDecCnt, 0, "decoded count cleared");
    wbReadCheck(regIllCnt, 0, "illegal count cleared");
  endtask

  initial begin
    void'($urandom(55245));
    reset      = 1'b1;
    instr      = '0;
    instrValid = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = regCtrl;
    datW       = '0;
    expDec     = 0;
    expIll     = 0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    testAfterReset();
    testRvDecode();
    testIsaSwitch();
    testIllegal();
    testStallFlush();
    testRegBlock();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* sim.f */
+incdir+hw
+incdir+tb
hw/isaPkg.sv
hw/wbPkg.sv
hw/rvDecoder.sv
hw/armDecoder.sv
hw/isaSelect.sv
hw/decodeStage.sv
hw/decodeCsr.sv
hw/dualDecodeTop.sv
tb/dualDecodeTb.sv
